// File: hdl/sound_pkg.sv
/* Constants shared by the sound board RTL and the testbench model
   ADPCM tables follow the usual OKI 4-bit format with 49 step sizes */
package sound_pkg;

    localparam int addr_w = 16;              // Sound CPU address bus
    localparam int data_w = 8;

    localparam logic [3:0] io_page = 4'hf;   // F000-FFFF
    localparam logic [2:0] io_fm     = 3'd0; // Register index from A[3:1]
    localparam logic [2:0] io_oki    = 3'd1;
    localparam logic [2:0] io_bank   = 3'd2;
    localparam logic [2:0] io_rate   = 3'd3;
    localparam logic [2:0] io_latch0 = 3'd4;
    localparam logic [2:0] io_latch1 = 3'd5;

    localparam int ram_aw   = 11;            // 2 KB work RAM
    localparam int adpcm_aw = 18;            // Sample ROM

    localparam logic [4:0] phrase_bytes = 5'd16;

    // ADPCM clock enables per output sample
    localparam logic [7:0] rate_div_slow = 8'd165;
    localparam logic [7:0] rate_div_fast = 8'd132;

    localparam logic [5:0] cen_num = 6'd1;
    localparam logic [5:0] cen_den = 6'd48;

    localparam logic [11:0] adpcm_step_table [0:48] = '{
        12'd16,   12'd17,   12'd19,   12'd21,   12'd23,   12'd25,   12'd28,
        12'd31,   12'd34,   12'd37,   12'd41,   12'd45,   12'd50,   12'd55,
        12'd60,   12'd66,   12'd73,   12'd80,   12'd88,   12'd97,   12'd107,
        12'd118,  12'd130,  12'd143,  12'd157,  12'd173,  12'd190,  12'd209,
        12'd230,  12'd253,  12'd279,  12'd307,  12'd337,  12'd371,  12'd408,
        12'd449,  12'd494,  12'd544,  12'd598,  12'd658,  12'd724,  12'd796,
        12'd876,  12'd963,  12'd1060, 12'd1166, 12'd1282, 12'd1411, 12'd1552
    };

    // Indexed by the magnitude bits of the nibble
    localparam logic signed [4:0] adpcm_index_adjust [0:7] = '{
        -5'sd1, -5'sd1, -5'sd1, -5'sd1, 5'sd2, 5'sd4, 5'sd6, 5'sd8
    };

endpackage

// File: hdl/frac_cen.sv
`timescale 1ns/10ps
/* Fractional clock enable, cen_num pulses every cen_den clocks
   cen is registered and lasts one clock */
module frac_cen (
    input  logic clk,
    input  logic rst,
    output logic cen
);

    logic [$bits(sound_pkg::cen_den)-1:0] acc;
    logic [$bits(sound_pkg::cen_den):0]   acc_nxt;   // One spare bit for the carry

    assign acc_nxt = acc + sound_pkg::cen_num;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            acc <= '0;
            cen <= 1'b0;
        end else if (acc_nxt >= sound_pkg::cen_den) begin
            acc <= acc_nxt[$bits(acc)-1:0] - sound_pkg::cen_den;       // Wrap
            cen <= 1'b1;
        end else begin
            acc <= acc_nxt[$bits(acc)-1:0];
            cen <= 1'b0;
        end
    end

endmodule

// File: hdl/sound_ram.sv
`timescale 1ns/10ps
/* Single-port work RAM, read data one clock after the address
   Contents are undefined after power-up */
module sound_ram (
    input  logic                             clk,
    input  logic [sound_pkg::ram_aw-1:0]     addr,
    input  logic [sound_pkg::data_w-1:0]     wdata,
    input  logic                             we,
    output logic [sound_pkg::data_w-1:0]     rdata
);

    logic [sound_pkg::data_w-1:0] mem [0:(1 << sound_pkg::ram_aw)-1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];   // Old data on a write cycle
    end

endmodule

// File: hdl/sound_bus_decode.sv
`timescale 1ns/10ps
/* Sound CPU address decode, selects are only active with mreq_n low
   RAM reads return data one clock after the address, others are combinational
   Bank and rate registers are write only and read back as FF */
module sound_bus_decode (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [sound_pkg::addr_w-1:0]  cpu_addr,
    input  logic [sound_pkg::data_w-1:0]  cpu_dout,
    input  logic                          mreq_n,
    input  logic                          wr_n,
    output logic [sound_pkg::data_w-1:0]  cpu_din,
    input  logic [sound_pkg::data_w-1:0]  snd_latch0,
    input  logic [sound_pkg::data_w-1:0]  snd_latch1,
    output logic [sound_pkg::addr_w-1:0]  rom_addr,
    output logic                          rom_cs,
    input  logic [sound_pkg::data_w-1:0]  rom_data,
    output logic                          fm_cs,
    input  logic [sound_pkg::data_w-1:0]  fm_dout,
    output logic                          oki_wr,
    output logic [sound_pkg::data_w-1:0]  oki_wdata,
    output logic                          rate_sel,
    input  logic                          busy
);

    logic ram_cs, oki_cs, bank_cs, rate_cs, latch0_cs, latch1_cs;
    logic wr;
    logic bank;
    logic [sound_pkg::data_w-1:0] ram_rdata;

    assign wr = ~mreq_n & ~wr_n;

    always_comb begin
        rom_cs    = 1'b0;
        ram_cs    = 1'b0;
        fm_cs     = 1'b0;
        oki_cs    = 1'b0;
        bank_cs   = 1'b0;
        rate_cs   = 1'b0;
        latch0_cs = 1'b0;
        latch1_cs = 1'b0;
        if (!mreq_n) begin
            if (cpu_addr[15:14] != 2'b11) begin
                rom_cs = 1'b1;             // Fixed and banked windows
            end else if (cpu_addr[15:12] == 4'hd) begin
                ram_cs = 1'b1;
            end else if (cpu_addr[15:12] == sound_pkg::io_page) begin
                case (cpu_addr[3:1])
                    sound_pkg::io_fm:     fm_cs     = 1'b1;
                    sound_pkg::io_oki:    oki_cs    = 1'b1;
                    sound_pkg::io_bank:   bank_cs   = 1'b1;
                    sound_pkg::io_rate:   rate_cs   = 1'b1;
                    sound_pkg::io_latch0: latch0_cs = 1'b1;
                    sound_pkg::io_latch1: latch1_cs = 1'b1;
                    default: ;
                endcase
            end
        end
    end

    // 8000-BFFF maps into the upper half of the ROM through the bank bit
    assign rom_addr = cpu_addr[15] ? {1'b1, bank, cpu_addr[13:0]} : cpu_addr;

    assign oki_wr    = oki_cs & wr;
    assign oki_wdata = cpu_dout;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            bank     <= 1'b0;
            rate_sel <= 1'b0;
        end else if (wr) begin
            if (bank_cs) bank <= cpu_dout[0];
            if (rate_cs) rate_sel <= cpu_dout[0];
        end
    end

    sound_ram u_ram (
        .clk   (clk),
        .addr  (cpu_addr[sound_pkg::ram_aw-1:0]),
        .wdata (cpu_dout),
        .we    (ram_cs & wr),
        .rdata (ram_rdata)
    );

    always_comb begin
        if (fm_cs)          cpu_din = fm_dout;
        else if (latch0_cs) cpu_din = snd_latch0;
        else if (latch1_cs) cpu_din = snd_latch1;
        else if (ram_cs)    cpu_din = ram_rdata;
        else if (rom_cs)    cpu_din = rom_data;
        else if (oki_cs)    cpu_din = {{(sound_pkg::data_w-1){1'b0}}, busy}; // Status
        else                cpu_din = '1;
    end

endmodule

// File: hdl/adpcm_fetch.sv
`timescale 1ns/10ps
/* Single-voice phrase player, fixed length phrases starting at page*1024
   Sample-ROM data is ignored on the first cycle after an address change
   A late byte delays its nibble, a tick arriving while one is owed is lost */
module adpcm_fetch (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            cen_oki,
    input  logic                            oki_wr,
    input  logic [sound_pkg::data_w-1:0]    oki_wdata,
    input  logic                            rate_sel,
    output logic [sound_pkg::adpcm_aw-1:0]  adpcm_addr,
    input  logic [7:0]                      adpcm_data,
    input  logic                            adpcm_ok,
    output logic                            nib_valid,
    output logic [3:0]                      nibble,
    output logic                            phrase_start,
    output logic                            busy
);

    logic [$bits(sound_pkg::rate_div_slow)-1:0] div_cnt, div_last;
    logic [$clog2(sound_pkg::phrase_bytes)-1:0] byte_cnt;
    logic start, stop, tick, due, settle, have_byte, byte_ready, issue, half;
    logic [7:0] byte_q, cur_byte;

    assign start      = oki_wr & oki_wdata[7];
    assign stop       = oki_wr & ~oki_wdata[7];
    assign div_last   = rate_sel ? sound_pkg::rate_div_slow - 1'b1
                                 : sound_pkg::rate_div_fast - 1'b1;
    assign tick       = busy & cen_oki & (div_cnt >= div_last);
    assign byte_ready = have_byte | (~settle & adpcm_ok);
    assign cur_byte   = have_byte ? byte_q : adpcm_data;
    assign issue      = busy & (due | tick) & byte_ready;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
        end else if (start) begin
            div_cnt <= '0;
        end else if (cen_oki) begin
            div_cnt <= (div_cnt >= div_last) ? '0 : div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            busy         <= 1'b0;
            due          <= 1'b0;
            settle       <= 1'b0;
            have_byte    <= 1'b0;
            half         <= 1'b0;
            byte_cnt     <= '0;
            nib_valid    <= 1'b0;
            phrase_start <= 1'b0;
            adpcm_addr   <= '0;
        end else begin
            nib_valid    <= issue;
            phrase_start <= start;      // Clears the decoder
            if (start) begin
                busy       <= 1'b1;
                due        <= 1'b0;
                settle     <= 1'b1;
                have_byte  <= 1'b0;
                half       <= 1'b0;
                byte_cnt   <= '0;
                adpcm_addr <= {1'b0, oki_wdata[6:0], 10'd0};
            end else if (stop) begin
                busy <= 1'b0;
                due  <= 1'b0;
            end else if (busy) begin
                due    <= (due | tick) & ~issue;
                settle <= 1'b0;
                if (issue && half) begin
                    half       <= 1'b0;
                    have_byte  <= 1'b0;
                    settle     <= 1'b1;  // Next address
                    byte_cnt   <= byte_cnt + 1'b1;
                    adpcm_addr <= adpcm_addr + 1'b1;
                    if (byte_cnt == sound_pkg::phrase_bytes - 1'b1) busy <= 1'b0;
                end else begin
                    if (issue) half <= 1'b1;
                    if (byte_ready) have_byte <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (byte_ready && !have_byte) byte_q <= adpcm_data;
        if (issue) nibble <= half ? cur_byte[3:0] : cur_byte[7:4];  // High nibble first
    end

endmodule

// File: hdl/adpcm_decode.sv
`timescale 1ns/10ps
/* OKI ADPCM decoder, 12-bit signed output clamped to -2048..2047
   Output and strobe follow nib_valid by one clock */
module adpcm_decode (
    input  logic                clk,
    input  logic                rst,
    input  logic                nib_valid,
    input  logic [3:0]          nibble,
    input  logic                phrase_start,
    output logic signed [11:0]  adpcm_snd,
    output logic                snd_valid
);

    localparam int last_index = $size(sound_pkg::adpcm_step_table) - 1;

    logic [5:0]         index, idx_nxt;
    logic [11:0]        step;
    logic signed [13:0] diff, sum;
    logic signed [6:0]  idx_sum;
    logic signed [11:0] snd_nxt;

    always_comb begin
        step = sound_pkg::adpcm_step_table[index];
        diff = 14'(step >> 3);
        if (nibble[0]) diff = diff + 14'(step >> 2);
        if (nibble[1]) diff = diff + 14'(step >> 1);
        if (nibble[2]) diff = diff + 14'(step);
        sum = nibble[3] ? adpcm_snd - diff : adpcm_snd + diff;  // Bit 3 is the sign

        if (sum > 14'sd2047)       snd_nxt = 12'sh7ff;
        else if (sum < -14'sd2048) snd_nxt = 12'sh800;
        else                       snd_nxt = sum[11:0];

        idx_sum = $signed({1'b0, index}) + sound_pkg::adpcm_index_adjust[nibble[2:0]];
        if (idx_sum < 0)                idx_nxt = '0;
        else if (idx_sum > last_index)  idx_nxt = 6'(last_index);
        else                            idx_nxt = idx_sum[5:0];
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            adpcm_snd <= '0;
            index     <= '0;
            snd_valid <= 1'b0;
        end else begin
            snd_valid <= nib_valid;
            if (phrase_start) begin
                adpcm_snd <= '0;
                index     <= '0;
            end else if (nib_valid) begin
                adpcm_snd <= snd_nxt;
                index     <= idx_nxt;
            end
        end
    end

endmodule

// File: hdl/sound_mixer.sv
`timescale 1ns/10ps
/* Stereo mixer, FM at half level plus ADPCM scaled by four
   The 16-bit sum wraps on overflow, outputs one clock after the inputs */
module sound_mixer (
    input  logic                clk,
    input  logic                enable_fm,
    input  logic                enable_adpcm,
    input  logic signed [15:0]  fm_left,
    input  logic signed [15:0]  fm_right,
    input  logic signed [11:0]  adpcm_snd,
    input  logic                snd_valid,
    output logic signed [15:0]  left,
    output logic signed [15:0]  right,
    output logic                sample
);

    function automatic logic signed [15:0] mix(
        input logic               en_fm,
        input logic               en_adpcm,
        input logic signed [15:0] fm,
        input logic signed [11:0] pcm
    );
        logic signed [15:0] fm_part, pcm_part;
        fm_part  = en_fm ? fm >>> 1 : 16'sd0;
        pcm_part = en_adpcm ? {{2{pcm[11]}}, pcm, 2'b00} : 16'sd0;
        return fm_part + pcm_part;
    endfunction

    always_ff @(posedge clk) begin
        left   <= mix(enable_fm, enable_adpcm, fm_left, adpcm_snd);
        right  <= mix(enable_fm, enable_adpcm, fm_right, adpcm_snd);
        sample <= snd_valid;    // Aligned with the mixed data
    end

endmodule

// File: hdl/sound_top.sv
`timescale 1ns/10ps
/* Sound board without CPU and FM synthesiser, both are driven from outside
   fm_left and fm_right are taken as given, no FM sample strobe is used
   sample marks new ADPCM-driven output data */
module sound_top (
    input  logic                            clk,
    input  logic                            rst,
    // Sound CPU bus
    input  logic [sound_pkg::addr_w-1:0]    cpu_addr,
    input  logic [sound_pkg::data_w-1:0]    cpu_dout,
    input  logic                            mreq_n,
    input  logic                            wr_n,
    output logic [sound_pkg::data_w-1:0]    cpu_din,
    // From main CPU
    input  logic [sound_pkg::data_w-1:0]    snd_latch0,
    input  logic [sound_pkg::data_w-1:0]    snd_latch1,
    // Program ROM
    output logic [sound_pkg::addr_w-1:0]    rom_addr,
    output logic                            rom_cs,
    input  logic [sound_pkg::data_w-1:0]    rom_data,
    // FM chip
    output logic                            fm_cs,
    input  logic [sound_pkg::data_w-1:0]    fm_dout,
    input  logic signed [15:0]              fm_left,
    input  logic signed [15:0]              fm_right,
    // Sample ROM
    output logic [sound_pkg::adpcm_aw-1:0]  adpcm_addr,
    input  logic [7:0]                      adpcm_data,
    input  logic                            adpcm_ok,
    // Mix
    input  logic                            enable_fm,
    input  logic                            enable_adpcm,
    output logic signed [15:0]              left,
    output logic signed [15:0]              right,
    output logic                            sample
);

    logic cen_oki;
    logic oki_wr, rate_sel, busy;
    logic [sound_pkg::data_w-1:0] oki_wdata;
    logic nib_valid, phrase_start, snd_valid;
    logic [3:0] nibble;
    logic signed [11:0] adpcm_snd;

    frac_cen u_okicen (
        .clk (clk),
        .rst (rst),
        .cen (cen_oki)
    );

    sound_bus_decode u_bus (
        .clk        (clk),
        .rst        (rst),
        .cpu_addr   (cpu_addr),
        .cpu_dout   (cpu_dout),
        .mreq_n     (mreq_n),
        .wr_n       (wr_n),
        .cpu_din    (cpu_din),
        .snd_latch0 (snd_latch0),
        .snd_latch1 (snd_latch1),
        .rom_addr   (rom_addr),
        .rom_cs     (rom_cs),
        .rom_data   (rom_data),
        .fm_cs      (fm_cs),
        .fm_dout    (fm_dout),
        .oki_wr     (oki_wr),
        .oki_wdata  (oki_wdata),
        .rate_sel   (rate_sel),
        .busy       (busy)
    );

    adpcm_fetch u_fetch (
        .clk          (clk),
        .rst          (rst),
        .cen_oki      (cen_oki),
        .oki_wr       (oki_wr),
        .oki_wdata    (oki_wdata),
        .rate_sel     (rate_sel),
        .adpcm_addr   (adpcm_addr),
        .adpcm_data   (adpcm_data),
        .adpcm_ok     (adpcm_ok),
        .nib_valid    (nib_valid),
        .nibble       (nibble),
        .phrase_start (phrase_start),
        .busy         (busy)
    );

    adpcm_decode u_decode (
        .clk          (clk),
        .rst          (rst),
        .nib_valid    (nib_valid),
        .nibble       (nibble),
        .phrase_start (phrase_start),
        .adpcm_snd    (adpcm_snd),
        .snd_valid    (snd_valid)
    );

    sound_mixer u_mixer (
        .clk          (clk),
        .enable_fm    (enable_fm),
        .enable_adpcm (enable_adpcm),
        .fm_left      (fm_left),
        .fm_right     (fm_right),
        .adpcm_snd    (adpcm_snd),
        .snd_valid    (snd_valid),
        .left         (left),
        .right        (right),
        .sample       (sample)
    );

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/10ps
/* Free-running testbench clock, 4 ns period, starts low */
module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

endmodule

// File: bench/sound_checker.sv
`timescale 1ns/10ps
/* Port-level assertions on sound_top, bound into the DUT
   fails counts assertion failures for the end-of-run summary */
module sound_checker (
    input logic                            clk,
    input logic                            rst,
    input logic [sound_pkg::addr_w-1:0]    cpu_addr,
    input logic [sound_pkg::data_w-1:0]    cpu_dout,
    input logic                            mreq_n,
    input logic                            wr_n,
    input logic                            rom_cs,
    input logic                            fm_cs,
    input logic [sound_pkg::adpcm_aw-1:0]  adpcm_addr,
    input logic                            adpcm_ok,
    input logic                            sample
);

    int   fails = 0;
    logic started;     // A phrase start was written since reset
    logic oki_start;

    assign oki_start = !mreq_n && !wr_n && cpu_addr[15:12] == sound_pkg::io_page
                       && cpu_addr[3:1] == sound_pkg::io_oki && cpu_dout[7];

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            started <= 1'b0;
        end else if (oki_start) begin
            started <= 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(rom_cs && fm_cs))
        else begin
            fails++;
            $error("rom_cs and fm_cs high together");
        end

    assert property (@(posedge clk) disable iff (rst) sample |=> !sample)
        else begin
            fails++;
            $error("sample longer than one cycle");
        end

    // No write on the bus, so only the fetch can move the address
    assert property (@(posedge clk) disable iff (rst)
                     (!adpcm_ok && (wr_n || mreq_n)) |=> $stable(adpcm_addr))
        else begin
            fails++;
            $error("adpcm_addr moved while waiting for adpcm_ok");
        end

    assert property (@(posedge clk) disable iff (rst) !started |-> !sample)
        else begin
            fails++;
            $error("sample pulse before any phrase start");
        end

endmodule

// File: bench/sound_tb.sv
`timescale 1ns/10ps
/* Directed tests for sound_top, the testbench plays the sound CPU and FM chip
   Sample ROM answers two cycles after an address change
   Inputs change on the falling edge, outputs are read on the falling edge */
module sound_tb;

    localparam int phrase_nibbles = 2 * int'(sound_pkg::phrase_bytes);
    localparam int slow_spacing   = int'(sound_pkg::rate_div_slow) * int'(sound_pkg::cen_den);
    localparam int timeout_cycles = 3 * phrase_nibbles * slow_spacing + 20000;

    logic                           clk, rst;
    logic [sound_pkg::addr_w-1:0]   cpu_addr, rom_addr;
    logic [sound_pkg::data_w-1:0]   cpu_dout, cpu_din, snd_latch0, snd_latch1;
    logic [sound_pkg::data_w-1:0]   rom_data, fm_dout;
    logic                           mreq_n, wr_n, rom_cs, fm_cs;
    logic signed [15:0]             fm_left, fm_right, left, right;
    logic [sound_pkg::adpcm_aw-1:0] adpcm_addr, last_addr;
    logic [7:0]                     adpcm_data;
    logic                           adpcm_ok, enable_fm, enable_adpcm, sample;
    logic                           rd_rom_cs, rd_fm_cs;   // Selects seen during the last read

    logic [7:0]         rom_mem [0:(1 << sound_pkg::adpcm_aw)-1];   // Sample ROM
    logic signed [15:0] exp_q [$];
    integer             seed = 12782;
    int                 ok_wait = 2;
    int                 cycle = 0;
    int                 checks = 0;
    int                 errors = 0;

    tb_clock clk_i (.clk(clk));

    sound_top dut_i (.*);

    bind sound_top sound_checker chk_i (
        .clk(clk), .rst(rst), .cpu_addr(cpu_addr), .cpu_dout(cpu_dout),
        .mreq_n(mreq_n), .wr_n(wr_n), .rom_cs(rom_cs), .fm_cs(fm_cs),
        .adpcm_addr(adpcm_addr), .adpcm_ok(adpcm_ok), .sample(sample)
    );

    // Program ROM contents as a function of the full address
    function automatic logic [7:0] prog_byte(input logic [15:0] addr);
        return 8'(addr[7:0] + 8'd3 * addr[15:8]) ^ 8'h5a;
    endfunction

    assign rom_data = prog_byte(rom_addr);

    // Sample ROM, data follows the address, ok two cycles after a change
    always @(negedge clk) begin
        if (adpcm_addr !== last_addr) begin
            last_addr = adpcm_addr;
            ok_wait = 2;
            adpcm_ok = 1'b0;
        end else begin
            if (ok_wait > 0) ok_wait = ok_wait - 1;
            adpcm_ok = (ok_wait == 0);
        end
        adpcm_data = rom_mem[adpcm_addr];
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle >= timeout_cycles) begin
            $display("timeout: run still going after %0d cycles", cycle);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic logic [15:0] io_addr(input logic [2:0] idx);
        return {sound_pkg::io_page, 8'h00, idx, 1'b0};
    endfunction

    function automatic int half_floor(input int v);
        return (v - (v & 1)) / 2;    // Rounds toward minus infinity
    endfunction

    // Expected left/right values for one phrase, OKI rule on the ROM bytes
    function automatic void model_phrase(input int page);
        int sig, idx, step, diff;
        logic [7:0] b;
        logic [3:0] nib;
        sig = 0;
        idx = 0;
        exp_q.delete();
        for (int k = 0; k < phrase_nibbles; k++) begin
            b = rom_mem[page * 1024 + k / 2];
            nib = (k % 2 == 0) ? b[7:4] : b[3:0];
            step = int'(sound_pkg::adpcm_step_table[idx]);
            diff = step / 8;
            if (nib[0]) diff = diff + step / 4;
            if (nib[1]) diff = diff + step / 2;
            if (nib[2]) diff = diff + step;
            sig = nib[3] ? sig - diff : sig + diff;
            if (sig > 2047) sig = 2047;
            else if (sig < -2048) sig = -2048;
            idx = idx + int'(sound_pkg::adpcm_index_adjust[nib[2:0]]);
            if (idx < 0) idx = 0;
            else if (idx > 48) idx = 48;
            exp_q.push_back(16'(sig * 4));
        end
    endfunction

    task automatic check_byte(input string what, input logic [sound_pkg::data_w-1:0] got,
                              input logic [sound_pkg::data_w-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %0t ns: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input string what, input logic [sound_pkg::addr_w-1:0] got,
                              input logic [sound_pkg::addr_w-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_sample(input string what, input logic signed [15:0] got,
                                input logic signed [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        @(negedge clk);
        cpu_addr = addr;
        cpu_dout = data;
        mreq_n = 1'b0;
        wr_n = 1'b0;
        @(negedge clk);
        mreq_n = 1'b1;
        wr_n = 1'b1;
    endtask

    // Sampled one cycle after the address, which also covers RAM latency
    task automatic bus_read(input logic [15:0] addr, output logic [7:0] data,
                            output logic [15:0] raddr);
        @(negedge clk);
        cpu_addr = addr;
        mreq_n = 1'b0;
        wr_n = 1'b1;
        @(negedge clk);
        data = cpu_din;
        raddr = rom_addr;
        rd_rom_cs = rom_cs;
        rd_fm_cs = fm_cs;
        mreq_n = 1'b1;
    endtask

    task automatic wait_sample();
        do @(negedge clk); while (sample !== 1'b1);
    endtask

    task automatic report_test(input string name, input int err0);
        $display("test %s done, %0d errors", name, errors - err0);
    endtask

    task automatic test_rom_decode();
        logic [15:0] low [3] = '{16'h0000, 16'h1234, 16'h7fff};
        logic [15:0] banked [3] = '{16'h8000, 16'ha5a5, 16'hbfff};
        logic [15:0] raddr, exp_addr;
        logic [7:0]  data;
        int          err0;
        err0 = errors;
        foreach (low[i]) begin
            bus_read(low[i], data, raddr);
            check_addr("rom_addr", raddr, low[i]);
            check_byte("program rom", data, prog_byte(low[i]));
            check_flag("rom_cs", rd_rom_cs, 1'b1);
            check_flag("fm_cs on rom read", rd_fm_cs, 1'b0);
        end
        for (int bank = 0; bank < 2; bank++) begin
            bus_write(io_addr(sound_pkg::io_bank), 8'(bank));
            foreach (banked[i]) begin
                exp_addr = {1'b1, 1'(bank), banked[i][13:0]};
                bus_read(banked[i], data, raddr);
                check_addr("banked rom_addr", raddr, exp_addr);
                check_byte("banked rom", data, prog_byte(exp_addr));
                check_flag("banked rom_cs", rd_rom_cs, 1'b1);
            end
        end
        report_test("program rom decode", err0);
    endtask

    task automatic test_latch_ram();
        logic [15:0] ram_a [3] = '{16'hd000, 16'hd7ff, 16'hd3a5};
        logic [7:0]  ram_d [3];
        logic [15:0] raddr;
        logic [7:0]  data;
        int          err0;
        err0 = errors;
        @(negedge clk);
        snd_latch0 = 8'($random(seed));
        snd_latch1 = 8'($random(seed));
        fm_dout = 8'($random(seed));
        bus_read(io_addr(sound_pkg::io_latch0), data, raddr);
        check_byte("latch0", data, snd_latch0);
        check_flag("fm_cs on latch0", rd_fm_cs, 1'b0);
        bus_read(io_addr(sound_pkg::io_latch1), data, raddr);
        check_byte("latch1", data, snd_latch1);
        foreach (ram_a[i]) begin
            ram_d[i] = 8'($random(seed));
            bus_write(ram_a[i], ram_d[i]);
        end
        foreach (ram_a[i]) begin
            bus_read(ram_a[i], data, raddr);
            check_byte("ram", data, ram_d[i]);
            check_flag("rom_cs on ram", rd_rom_cs, 1'b0);
        end
        bus_read(io_addr(3'd6), data, raddr);
        check_byte("unused io 6", data, 8'hff);
        bus_read(io_addr(3'd7), data, raddr);
        check_byte("unused io 7", data, 8'hff);
        bus_read(16'he000, data, raddr);
        check_byte("unmapped e000", data, 8'hff);
        bus_read(16'hc123, data, raddr);
        check_byte("unmapped c123", data, 8'hff);
        check_flag("rom_cs at c123", rd_rom_cs, 1'b0);
        bus_read(io_addr(sound_pkg::io_fm), data, raddr);
        check_byte("fm status", data, fm_dout);
        check_flag("fm_cs", rd_fm_cs, 1'b1);
        check_flag("rom_cs on fm read", rd_rom_cs, 1'b0);
        report_test("latches, ram and unmapped", err0);
    endtask

    task automatic test_mixer();
        logic signed [15:0] exp_l, exp_r;
        int                 err0;
        err0 = errors;
        @(negedge clk);
        fm_left = 16'sd4661;
        fm_right = -16'sd1001;
        for (int c = 0; c < 4; c++) begin
            @(negedge clk);
            enable_fm = c[0];
            enable_adpcm = c[1];
            @(negedge clk);
            // ADPCM is idle at zero, so its enable adds nothing
            exp_l = c[0] ? 16'(half_floor(int'(fm_left))) : 16'sd0;
            exp_r = c[0] ? 16'(half_floor(int'(fm_right))) : 16'sd0;
            check_sample("mixer left", left, exp_l);
            check_sample("mixer right", right, exp_r);
        end
        report_test("mixer enables", err0);
    endtask

    task automatic test_phrase();
        int err0;
        err0 = errors;
        @(negedge clk);
        enable_fm = 1'b0;
        enable_adpcm = 1'b1;
        model_phrase(5);
        bus_write(io_addr(sound_pkg::io_oki), 8'h85);
        for (int k = 0; k < phrase_nibbles; k++) begin
            wait_sample();
            check_sample("adpcm left", left, exp_q[k]);
            check_sample("adpcm right", right, exp_q[k]);
        end
        report_test("adpcm phrase", err0);
    endtask

    task automatic test_end_stop_rate();
        logic [15:0] raddr;
        logic [7:0]  data;
        int          err0, t_prev;
        err0 = errors;
        bus_write(io_addr(sound_pkg::io_oki), 8'h89);
        bus_read(io_addr(sound_pkg::io_oki), data, raddr);
        check_byte("busy while playing", data, 8'h01);
        repeat (phrase_nibbles) wait_sample();
        bus_read(io_addr(sound_pkg::io_oki), data, raddr);
        check_byte("busy after phrase", data, 8'h00);

        bus_write(io_addr(sound_pkg::io_oki), 8'h82);
        repeat (2) wait_sample();
        bus_write(io_addr(sound_pkg::io_oki), 8'h00);     // Stop
        bus_read(io_addr(sound_pkg::io_oki), data, raddr);
        check_byte("busy after stop", data, 8'h00);

        bus_write(io_addr(sound_pkg::io_rate), 8'h01);
        bus_write(io_addr(sound_pkg::io_oki), 8'h83);
        wait_sample();
        t_prev = cycle;
        repeat (2) begin
            wait_sample();
            checks++;
            if (cycle - t_prev < slow_spacing) begin
                errors++;
                $display("error %0t ns: sample pulses came only %0d cycles apart at the slow rate",
                         $time, cycle - t_prev);
            end
            t_prev = cycle;
        end
        bus_write(io_addr(sound_pkg::io_oki), 8'h00);
        report_test("phrase end, stop and rate", err0);
    endtask

    initial begin
        rst = 1'b1;
        cpu_addr = '0;
        cpu_dout = '0;
        mreq_n = 1'b1;
        wr_n = 1'b1;
        snd_latch0 = '0;
        snd_latch1 = '0;
        fm_dout = '0;
        fm_left = '0;
        fm_right = '0;
        enable_fm = 1'b0;
        enable_adpcm = 1'b0;
        adpcm_data = '0;
        adpcm_ok = 1'b0;
        last_addr = '0;
        rd_rom_cs = 1'b0;
        rd_fm_cs = 1'b0;
        for (int i = 0; i < (1 << sound_pkg::adpcm_aw); i++) begin
            rom_mem[i] = 8'($random(seed));
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_rom_decode();
        test_latch_ram();
        test_mixer();
        test_phrase();
        test_end_stop_rate();

        repeat (4) @(negedge clk);
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, dut_i.chk_i.fails);
        if (errors == 0 && dut_i.chk_i.fails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: sim.f
hdl/sound_pkg.sv
hdl/frac_cen.sv
hdl/sound_ram.sv
hdl/sound_bus_decode.sv
hdl/adpcm_fetch.sv
hdl/adpcm_decode.sv
hdl/sound_mixer.sv
hdl/sound_top.sv
bench/tb_clock.sv
bench/sound_checker.sv
bench/sound_tb.sv
